// ==== src/wb_path_pkg.sv ====
/* Shared types for the late writeback path.
   vec_t is fixed at NUM_LANES_DEFAULT lanes, and lane 0 sits in the low bits. */

package wb_path_pkg;

  // ----------------------------
  // Widths
  // ----------------------------

  localparam int NUM_LANES_DEFAULT = 4;
  localparam int REG_ADDR_W        = 5;

  // ----------------------------
  // Data
  // ----------------------------

  typedef logic [31:0] word_t;

  // Lane 0 in bits [31:0]
  typedef word_t [NUM_LANES_DEFAULT-1:0] vec_t;

  // ----------------------------
  // Control
  // ----------------------------

  // Load subword kinds, same encoding as the decode side
  typedef enum logic [2:0] {
    LOAD_W  = 3'd0,
    LOAD_B  = 3'd1,
    LOAD_BU = 3'd2,
    LOAD_H  = 3'd3,
    LOAD_HU = 3'd4
  } load_kind_e;

  // Per memory port response holding register control
  typedef struct packed {
    logic queue_en;
    logic queue_val;
  } queue_ctrl_t;

  // M stage control, load kind shared by all ports
  typedef struct packed {
    load_kind_e load_kind;
    logic       wb_sel;
  } mem_ctrl_t;

  // One hold bit per late stage
  typedef struct packed {
    logic m;
    logic x2;
    logic x3;
    logic w;
  } stall_t;

endpackage

// ==== src/load_format.sv ====
/* Formats one memory port response and keeps a one-entry holding copy.
   The holding register has no reset and is only meaningful after a queue_en cycle. */

`timescale 1ns/1ps

module load_format (
  input  logic                     clk,
  input  wb_path_pkg::word_t       resp_data,
  input  wb_path_pkg::load_kind_e  load_kind,
  input  wb_path_pkg::queue_ctrl_t qctrl,
  output wb_path_pkg::word_t       load_value
);

  import wb_path_pkg::*;

  word_t formatted;
  word_t held;

  // ----------------------------
  // Subword extraction
  // ----------------------------

  always_comb begin
    case (load_kind)
      LOAD_W:  formatted = resp_data;
      LOAD_B:  formatted = {{24{resp_data[7]}}, resp_data[7:0]};
      LOAD_BU: formatted = {24'd0, resp_data[7:0]};
      LOAD_H:  formatted = {{16{resp_data[15]}}, resp_data[15:0]};
      LOAD_HU: formatted = {16'd0, resp_data[15:0]};
      default: formatted = '0;
    endcase
  end

  // ----------------------------
  // Holding register
  // ----------------------------

  // Captures the already formatted value
  always_ff @(posedge clk) begin
    if (qctrl.queue_en) begin
      held <= formatted;
    end
  end

  // Held copy wins when the response arrived during a stall
  assign load_value = qctrl.queue_val ? held : formatted;

  // Decode must never hand us an unused kind encoding
  a_legal_kind: assert property (
    @(posedge clk) disable iff ($isunknown(load_kind))
    load_kind inside {LOAD_W, LOAD_B, LOAD_BU, LOAD_H, LOAD_HU}
  ) else $error("load_format: illegal load kind %0d", load_kind);

endmodule

// ==== src/mem_stage.sv ====
/* Memory stage: formats the scalar and lane load responses and picks the writeback value.
   Purely combinational apart from the per-port holding registers.
   NUM_LANES must match the lane count of vec_t. */

`timescale 1ns/1ps

module mem_stage #(
  parameter int NUM_LANES = wb_path_pkg::NUM_LANES_DEFAULT
) (
  input  logic                                     clk,
  input  wb_path_pkg::word_t                       exec_result,
  input  wb_path_pkg::vec_t                        v_exec_result,
  input  wb_path_pkg::word_t                       dmemresp_data,
  input  wb_path_pkg::vec_t                        v_dmemresp_data,
  input  wb_path_pkg::mem_ctrl_t                   ctrl,
  input  wb_path_pkg::queue_ctrl_t                 qctrl,
  input  wb_path_pkg::queue_ctrl_t [NUM_LANES-1:0] v_qctrl,
  output wb_path_pkg::word_t                       wb_value,
  output wb_path_pkg::vec_t                        v_wb_value
);

  import wb_path_pkg::*;

  word_t load_value;
  vec_t  v_load_value;

  if (NUM_LANES != NUM_LANES_DEFAULT) begin : g_lane_check
    $error("mem_stage: NUM_LANES %0d does not match vec_t", NUM_LANES);
  end

  // ----------------------------
  // Load response formatting
  // ----------------------------

  load_format scalar_fmt (
    .clk        (clk),
    .resp_data  (dmemresp_data),
    .load_kind  (ctrl.load_kind),
    .qctrl      (qctrl),
    .load_value (load_value)
  );

  // Lanes share the load kind but each has its own holding register
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    load_format lane_fmt (
      .clk        (clk),
      .resp_data  (v_dmemresp_data[i]),
      .load_kind  (ctrl.load_kind),
      .qctrl      (v_qctrl[i]),
      .load_value (v_load_value[i])
    );
  end

  // ----------------------------
  // Writeback select
  // ----------------------------

  // One select covers the scalar word and the whole vector
  assign wb_value   = ctrl.wb_sel ? load_value : exec_result;
  assign v_wb_value = ctrl.wb_sel ? v_load_value : v_exec_result;

endmodule

// ==== src/late_pipe.sv ====
/* X2, X3 and W stage registers for one payload, each held by its own stall bit.
   No reset, so out_w is undefined until the pipe has filled. */

`timescale 1ns/1ps

module late_pipe #(
  parameter type payload_t = wb_path_pkg::word_t
) (
  input  logic                clk,
  input  wb_path_pkg::stall_t stall,
  input  payload_t            in_m,
  output payload_t            out_w
);

  payload_t x2_q;
  payload_t x3_q;
  payload_t w_q;

  // ----------------------------
  // Stage registers
  // ----------------------------

  always_ff @(posedge clk) begin
    if (!stall.x2) begin
      x2_q <= in_m;
    end
  end

  // Nothing is selected at X3 here, plain copy
  always_ff @(posedge clk) begin
    if (!stall.x3) begin
      x3_q <= x2_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall.w) begin
      w_q <= x3_q;
    end
  end

  assign out_w = w_q;

  // A stalled stage must also hold everything behind it,
  // otherwise a value would be overwritten in flight
  a_stall_order: assert property (
    @(posedge clk) disable iff ($isunknown(stall))
    (stall.w -> stall.x3) && (stall.x3 -> stall.x2) && (stall.x2 -> stall.m)
  ) else $error("late_pipe: stall order broken m=%b x2=%b x3=%b w=%b",
                stall.m, stall.x2, stall.x3, stall.w);

endmodule

// ==== src/regfile.sv ====
/* Scalar register file, two combinational read ports and one write port.
   Register 0 reads as zero and drops writes. Contents have no reset. */

`timescale 1ns/1ps

module regfile #(
  parameter int ADDR_W = 5
) (
  input  logic               clk,
  input  logic [ADDR_W-1:0]  raddr0,
  input  logic [ADDR_W-1:0]  raddr1,
  output wb_path_pkg::word_t rdata0,
  output wb_path_pkg::word_t rdata1,
  input  logic               wen,
  input  logic [ADDR_W-1:0]  waddr,
  input  wb_path_pkg::word_t wdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  wb_path_pkg::word_t regs [DEPTH];

  // ----------------------------
  // Write port
  // ----------------------------

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // ----------------------------
  // Read ports
  // ----------------------------

  // x0 forced here rather than stored
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // W stage control must present a clean address with every write
  a_waddr_known: assert property (
    @(posedge clk) wen |-> !$isunknown(waddr)
  ) else $error("regfile: write with unknown address %b", waddr);

endmodule

// ==== src/wb_path_top.sv ====
/* Late half of the vector datapath: memory stage, X2/X3/W pipes and scalar register file.
   Control arrives as plain selects and stalls, there is no handshake.
   wb_data_w doubles as the CSR write data. */

`timescale 1ns/1ps

module wb_path_top #(
  parameter int NUM_LANES  = wb_path_pkg::NUM_LANES_DEFAULT,
  parameter int REG_ADDR_W = wb_path_pkg::REG_ADDR_W
) (
  input  logic                                     clk,

  // M stage data and control
  input  wb_path_pkg::word_t                       exec_result_m,
  input  wb_path_pkg::vec_t                        v_exec_result_m,
  input  wb_path_pkg::word_t                       dmemresp_data,
  input  wb_path_pkg::vec_t                        v_dmemresp_data,
  input  wb_path_pkg::mem_ctrl_t                   mem_ctrl_m,
  input  wb_path_pkg::queue_ctrl_t                 queue_ctrl_m,
  input  wb_path_pkg::queue_ctrl_t [NUM_LANES-1:0] v_queue_ctrl_m,
  input  wb_path_pkg::stall_t                      stall,

  // W stage control
  input  logic                                     rf_wen_w,
  input  logic [REG_ADDR_W-1:0]                    rf_waddr_w,
  input  logic                                     isvec_w,

  // Register read
  input  logic [REG_ADDR_W-1:0]                    raddr0,
  input  logic [REG_ADDR_W-1:0]                    raddr1,
  output wb_path_pkg::word_t                       rdata0,
  output wb_path_pkg::word_t                       rdata1,

  // Writeback results
  output wb_path_pkg::word_t                       wb_data_w,
  output wb_path_pkg::vec_t                        v_wb_data_w
);

  import wb_path_pkg::*;

  word_t wb_value_m;
  vec_t  v_wb_value_m;
  logic  rf_wen;

  // ----------------------------
  // Memory stage
  // ----------------------------

  mem_stage #(
    .NUM_LANES (NUM_LANES)
  ) mem (
    .clk             (clk),
    .exec_result     (exec_result_m),
    .v_exec_result   (v_exec_result_m),
    .dmemresp_data   (dmemresp_data),
    .v_dmemresp_data (v_dmemresp_data),
    .ctrl            (mem_ctrl_m),
    .qctrl           (queue_ctrl_m),
    .v_qctrl         (v_queue_ctrl_m),
    .wb_value        (wb_value_m),
    .v_wb_value      (v_wb_value_m)
  );

  // ----------------------------
  // Late stages
  // ----------------------------

  late_pipe #(.payload_t(word_t)) scalar_pipe (
    .clk   (clk),
    .stall (stall),
    .in_m  (wb_value_m),
    .out_w (wb_data_w)
  );

  late_pipe #(.payload_t(vec_t)) vector_pipe (
    .clk   (clk),
    .stall (stall),
    .in_m  (v_wb_value_m),
    .out_w (v_wb_data_w)
  );

  // ----------------------------
  // Scalar register file
  // ----------------------------

  // Vector results never land in the scalar file
  assign rf_wen = rf_wen_w && !isvec_w;

  regfile #(
    .ADDR_W (REG_ADDR_W)
  ) rfile (
    .clk    (clk),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (rf_wen),
    .waddr  (rf_waddr_w),
    .wdata  (wb_data_w)
  );

endmodule

// ==== dv/wb_path_model.svh ====
/* Reference rules for load formatting, the holding register and the scalar register file.
   Included inside the testbench module, after the package import. */

`ifndef WB_PATH_MODEL_SVH
`define WB_PATH_MODEL_SVH

// Low byte or halfword, extended as the load kind asks
function automatic word_t fmt_load(word_t resp, load_kind_e kind);
  word_t res;
  case (kind)
    LOAD_B:  res = word_t'($signed(resp[7:0]));
    LOAD_BU: res = word_t'(resp[7:0]);
    LOAD_H:  res = word_t'($signed(resp[15:0]));
    LOAD_HU: res = word_t'(resp[15:0]);
    default: res = resp;
  endcase
  return res;
endfunction

// What one memory port presents, live or held
function automatic word_t port_value(word_t resp, load_kind_e kind, queue_ctrl_t qc,
                                     word_t held);
  return qc.queue_val ? held : fmt_load(resp, kind);
endfunction

function automatic word_t wb_choice(logic sel, word_t exec, word_t load);
  return sel ? load : exec;
endfunction

// Register contents after one W cycle, x0 stays zero
function automatic word_t next_reg(logic [REG_ADDR_W-1:0] addr, logic wen, logic isvec,
                                   word_t wdata, word_t old);
  word_t res;
  if (addr == '0) res = '0;
  else if (wen && !isvec) res = wdata;
  else res = old;
  return res;
endfunction

`endif

// ==== dv/wb_path_tb.sv ====
/* Testbench for wb_path_top. Concurrent assertions compare the W outputs and the
   register reads with values built from the model functions. */

`timescale 1ns/1ps

module wb_path_tb;

  import wb_path_pkg::*;

  `include "wb_path_model.svh"

  localparam int LANES = NUM_LANES_DEFAULT;

  logic                     clk;
  logic                     reset;
  word_t                    exec_result_m;
  vec_t                     v_exec_result_m;
  word_t                    dmemresp_data;
  vec_t                     v_dmemresp_data;
  mem_ctrl_t                mem_ctrl_m;
  queue_ctrl_t              queue_ctrl_m;
  queue_ctrl_t [LANES-1:0]  v_queue_ctrl_m;
  stall_t                   stall;
  logic                     rf_wen_w;
  logic [REG_ADDR_W-1:0]    rf_waddr_w;
  logic                     isvec_w;
  logic [REG_ADDR_W-1:0]    raddr0;
  logic [REG_ADDR_W-1:0]    raddr1;
  word_t                    rdata0;
  word_t                    rdata1;
  word_t                    wb_data_w;
  vec_t                     v_wb_data_w;

  // Expected M values and their three-edge delay line
  logic                     exp_vld_m;
  word_t                    exp_s_m;
  vec_t                     exp_v_m;
  logic                     flow_d [1:3];
  word_t                    exp_s_d [1:3];
  vec_t                     exp_v_d [1:3];
  word_t                    held_s;
  word_t                    held_v [LANES];
  logic                     ord_vld;
  word_t                    ord_s;
  vec_t                     ord_v;
  logic                     rd_chk;
  word_t                    rd_exp;
  word_t                    rf_model [2**REG_ADDR_W];
  string                    test_name;

  wb_path_top #(
    .NUM_LANES  (LANES),
    .REG_ADDR_W (REG_ADDR_W)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #10000;
    $display("Watchdog expired before the test sequence finished");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "check failed");
  endtask

  // ----------------------------
  // Checkers
  // ----------------------------

  // A flow counts only if M, X2 and X3 each moved on an unstalled edge
  always @(posedge clk) begin
    if (reset) begin
      flow_d[1] <= 1'b0;
      flow_d[2] <= 1'b0;
      flow_d[3] <= 1'b0;
    end else begin
      flow_d[1] <= exp_vld_m && (stall == '0);
      flow_d[2] <= flow_d[1] && (stall == '0);
      flow_d[3] <= flow_d[2] && (stall == '0);
    end
    exp_s_d[1] <= exp_s_m;
    exp_s_d[2] <= exp_s_d[1];
    exp_s_d[3] <= exp_s_d[2];
    exp_v_d[1] <= exp_v_m;
    exp_v_d[2] <= exp_v_d[1];
    exp_v_d[3] <= exp_v_d[2];
  end

  a_w_flow: assert property (@(posedge clk) disable iff (reset)
      flow_d[3] |-> (wb_data_w == exp_s_d[3]) && (v_wb_data_w == exp_v_d[3]))
    else fail_now($sformatf("Mismatch %s expected %h %h actual %h %h", test_name,
      $sampled(exp_s_d[3]), $sampled(exp_v_d[3]), $sampled(wb_data_w),
      $sampled(v_wb_data_w)));

  a_w_order: assert property (@(posedge clk) disable iff (reset)
      ord_vld |-> (wb_data_w == ord_s) && (v_wb_data_w == ord_v))
    else fail_now($sformatf("Mismatch %s expected %h %h actual %h %h", test_name,
      $sampled(ord_s), $sampled(ord_v), $sampled(wb_data_w), $sampled(v_wb_data_w)));

  a_rd: assert property (@(posedge clk) disable iff (reset)
      rd_chk |-> (rdata0 == rd_exp) && (rdata1 == rd_exp))
    else fail_now($sformatf("Mismatch %s expected %h actual %h %h", test_name,
      $sampled(rd_exp), $sampled(rdata0), $sampled(rdata1)));

  // ----------------------------
  // Stimulus helpers
  // ----------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic queue_ctrl_t make_qc(logic en, logic val);
    queue_ctrl_t q;
    q.queue_en  = en;
    q.queue_val = val;
    return q;
  endfunction

  // One M cycle with random data; expectation taken before the holding copy moves
  task automatic send(load_kind_e kind, logic sel, queue_ctrl_t qc,
                      queue_ctrl_t [LANES-1:0] vqc);
    exec_result_m = $urandom();
    dmemresp_data = $urandom();
    mem_ctrl_m.load_kind = kind;
    mem_ctrl_m.wb_sel    = sel;
    queue_ctrl_m   = qc;
    v_queue_ctrl_m = vqc;
    exp_s_m = wb_choice(sel, exec_result_m, port_value(dmemresp_data, kind, qc, held_s));
    if (qc.queue_en) held_s = fmt_load(dmemresp_data, kind);
    for (int i = 0; i < LANES; i++) begin
      v_exec_result_m[i] = $urandom();
      v_dmemresp_data[i] = $urandom();
      exp_v_m[i] = wb_choice(sel, v_exec_result_m[i],
                             port_value(v_dmemresp_data[i], kind, vqc[i], held_v[i]));
      if (vqc[i].queue_en) held_v[i] = fmt_load(v_dmemresp_data[i], kind);
    end
    exp_vld_m = 1'b1;
    next_cycle();
    exp_vld_m = 1'b0;
  endtask

  task automatic idle(int n);
    queue_ctrl_m   = '0;
    v_queue_ctrl_m = '0;
    repeat (n) next_cycle();
  endtask

  // Called in the W cycle of the value, reads back after the write edge
  task automatic write_and_read(logic [REG_ADDR_W-1:0] addr, logic isvec, word_t wdata);
    rf_wen_w   = 1'b1;
    rf_waddr_w = addr;
    isvec_w    = isvec;
    rf_model[addr] = next_reg(addr, 1'b1, isvec, wdata, rf_model[addr]);
    next_cycle();
    rf_wen_w = 1'b0;
    isvec_w  = 1'b0;
    raddr0   = addr;
    raddr1   = addr;
    rd_exp   = rf_model[addr];
    rd_chk   = 1'b1;
    next_cycle();
    rd_chk = 1'b0;
  endtask

  task automatic load_and_write(load_kind_e kind, logic sel, logic [REG_ADDR_W-1:0] addr,
                                logic isvec);
    send(kind, sel, '0, '0);
    idle(2);
    write_and_read(addr, isvec, exp_s_m);
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------

  initial begin
    load_kind_e              kinds [5];
    queue_ctrl_t [LANES-1:0] vq;
    word_t                   pend_s [4];
    vec_t                    pend_v [4];
    void'($urandom(32'hf41877f2));
    kinds = '{LOAD_W, LOAD_B, LOAD_BU, LOAD_H, LOAD_HU};
    reset = 1'b1;
    exec_result_m = '0;
    v_exec_result_m = '0;
    dmemresp_data = '0;
    v_dmemresp_data = '0;
    mem_ctrl_m = '0;
    queue_ctrl_m = '0;
    v_queue_ctrl_m = '0;
    stall = '0;
    rf_wen_w = 1'b0;
    rf_waddr_w = '0;
    isvec_w = 1'b0;
    raddr0 = '0;
    raddr1 = '0;
    exp_vld_m = 1'b0;
    ord_vld = 1'b0;
    rd_chk = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    idle(3);

    test_name = "load_format";
    for (int k = 0; k < 5; k++) begin
      load_and_write(kinds[k], 1'b1, REG_ADDR_W'(k + 1), 1'b0);
    end
    idle(3);

    test_name = "hold_reg";
    send(LOAD_H, 1'b1, make_qc(1'b1, 1'b0), '0);
    send(LOAD_B, 1'b1, make_qc(1'b0, 1'b1), '0);
    send(LOAD_W, 1'b1, make_qc(1'b0, 1'b1), '0);
    idle(3);

    test_name = "exec_select";
    repeat (4) send(LOAD_BU, 1'b0, make_qc(1'b1, 1'b1), '0);
    idle(3);

    // Lanes capture and replay on different cycles
    test_name = "vector_lanes";
    vq = {make_qc(1'b0, 1'b0), make_qc(1'b1, 1'b0), make_qc(1'b1, 1'b0), make_qc(1'b0, 1'b0)};
    send(LOAD_HU, 1'b1, '0, vq);
    vq = {make_qc(1'b0, 1'b0), make_qc(1'b1, 1'b1), make_qc(1'b0, 1'b1), make_qc(1'b1, 1'b0)};
    send(LOAD_B, 1'b1, '0, vq);
    vq = {make_qc(1'b1, 1'b0), make_qc(1'b0, 1'b1), make_qc(1'b0, 1'b0), make_qc(1'b0, 1'b1)};
    send(LOAD_H, 1'b1, '0, vq);
    idle(3);

    // Fill the pipe with A, B and C, freeze it with D waiting in M, then drain
    test_name = "stalls";
    for (int k = 0; k < 3; k++) begin
      send(LOAD_W, 1'b0, '0, '0);
      pend_s[k] = exp_s_m;
      pend_v[k] = exp_v_m;
    end
    stall = '1;
    send(LOAD_W, 1'b0, '0, '0);
    pend_s[3] = exp_s_m;
    pend_v[3] = exp_v_m;
    // W keeps A while frozen and up to the release edge
    ord_s   = pend_s[0];
    ord_v   = pend_v[0];
    ord_vld = 1'b1;
    repeat (3) next_cycle();
    stall = '0;
    next_cycle();
    for (int k = 1; k < 4; k++) begin
      ord_s = pend_s[k];
      ord_v = pend_v[k];
      next_cycle();
    end
    ord_vld = 1'b0;
    idle(3);

    test_name = "regfile";
    load_and_write(LOAD_W, 1'b0, REG_ADDR_W'(0), 1'b0);
    load_and_write(LOAD_W, 1'b0, REG_ADDR_W'(3), 1'b1);
    load_and_write(LOAD_W, 1'b0, REG_ADDR_W'(9), 1'b0);
    idle(4);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== wb_path.f ====
+incdir+dv
src/wb_path_pkg.sv
src/load_format.sv
src/mem_stage.sv
src/late_pipe.sv
src/regfile.sv
src/wb_path_top.sv
dv/wb_path_tb.sv
